//--- logic/asteroids_shell_pkg.sv
//////////////////////////////////////////////////
// asteroids shell shared definitions
// bridge widths and setting addresses, controller key
// bits, button vector layout and video widths
//////////////////////////////////////////////////

package asteroids_shell_pkg;

  //////////////////////////////////////////////////
  // host bridge
  //////////////////////////////////////////////////

  localparam int bridge_addr_w = 32;
  localparam int bridge_data_w = 32;

  // exact word addresses of the core settings
  localparam logic [bridge_addr_w-1:0] cs_language_addr   = 32'h8000_0000;
  localparam logic [bridge_addr_w-1:0] cs_ship_count_addr = 32'h9000_0000;
  localparam logic [bridge_addr_w-1:0] cs_test_mode_addr  = 32'h1000_0000;

  // every setting is two bits wide toward the game
  localparam int setting_w = 2;

  //////////////////////////////////////////////////
  // controllers
  //////////////////////////////////////////////////

  localparam int key_w = 32;

  // bit indices in a controller key word
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_face_a = 4;
  localparam int key_face_b = 5;
  localparam int key_face_x = 6;
  localparam int key_face_y = 7;
  localparam int key_start  = 15;

  // layout of the key bits kept per player after selection
  localparam int sel_right  = 0;
  localparam int sel_left   = 1;
  localparam int sel_fire   = 2;
  localparam int sel_hyper  = 3;
  localparam int sel_thrust = 4;
  localparam int sel_spare  = 5;
  localparam int sel_start  = 6;
  localparam int sel_w      = 7;

  // game button vector, active low
  localparam int button_w       = 8;
  localparam int btn_right      = 7;
  localparam int btn_left       = 6;
  localparam int btn_p1_start   = 5;
  localparam int btn_p2_start   = 4;
  localparam int btn_fire       = 3;
  localparam int btn_spare      = 2;
  localparam int btn_thrust     = 1;
  localparam int btn_hyperspace = 0;

  //////////////////////////////////////////////////
  // video
  //////////////////////////////////////////////////

  localparam int game_color_w = 4;
  localparam int rgb_w        = 24;

endpackage

//--- logic/core_settings_regs.sv
//////////////////////////////////////////////////
// core setting registers
// bridge writes to exact addresses update language,
// ship count and self-test toward the game core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_settings_regs (
  input  logic                                         clk_25_175,
  input  logic                                         rst_n,
  input  logic                                         bridge_wr,
  input  logic [asteroids_shell_pkg::bridge_addr_w-1:0] bridge_addr,
  input  logic [asteroids_shell_pkg::bridge_data_w-1:0] bridge_wr_data,
  output logic [asteroids_shell_pkg::setting_w-1:0]     cs_language,
  output logic [asteroids_shell_pkg::setting_w-1:0]     cs_ship_count,
  output logic                                         self_test_l
);

  // ship count and test mode keep only one stored bit
  logic ship_count_bit;
  logic test_mode_bit;

  // address decode, exact compare
  logic wr_language;
  logic wr_ship_count;
  logic wr_test_mode;

  assign wr_language   = bridge_wr && (bridge_addr == asteroids_shell_pkg::cs_language_addr);
  assign wr_ship_count = bridge_wr && (bridge_addr == asteroids_shell_pkg::cs_ship_count_addr);
  assign wr_test_mode  = bridge_wr && (bridge_addr == asteroids_shell_pkg::cs_test_mode_addr);

  always_ff @(posedge clk_25_175 or negedge rst_n) begin
    if (!rst_n) begin
      cs_language    <= '0;
      ship_count_bit <= 1'b0;
      test_mode_bit  <= 1'b0;
    end else begin
      // language takes both low data bits
      if (wr_language) begin
        cs_language <= bridge_wr_data[asteroids_shell_pkg::setting_w-1:0];
      end
      if (wr_ship_count) begin
        ship_count_bit <= bridge_wr_data[0];
      end
      if (wr_test_mode) begin
        test_mode_bit <= bridge_wr_data[0];
      end
    end
  end

  // upper ship count bit is never written
  assign cs_ship_count = {1'b0, ship_count_bit};

  // game expects self-test low when enabled
  assign self_test_l = ~test_mode_bit;

endmodule

//--- logic/arcade_controls.sv
//////////////////////////////////////////////////
// arcade controls
// two-flop synchronizer on the used key bits of both
// players, then the active-low game button vector
//////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_controls (
  input  logic                                    clk_25_175,
  input  logic                                    rst_n,
  input  logic [asteroids_shell_pkg::key_w-1:0]    cont1_key,
  input  logic [asteroids_shell_pkg::key_w-1:0]    cont2_key,
  output logic [asteroids_shell_pkg::button_w-1:0] buttons
);

  // player 0 is controller 1, player 1 is controller 2
  logic [asteroids_shell_pkg::key_w-1:0] key_in [2];

  // selected key bits per player, before and after sync
  logic [1:0][asteroids_shell_pkg::sel_w-1:0] key_sel;
  logic [1:0][asteroids_shell_pkg::sel_w-1:0] key_meta;
  logic [1:0][asteroids_shell_pkg::sel_w-1:0] key_sync;

  assign key_in[0] = cont1_key;
  assign key_in[1] = cont2_key;

  //////////////////////////////////////////////////
  // key selection
  //////////////////////////////////////////////////

  // only the bits the game uses go through the flops
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      key_sel[p][asteroids_shell_pkg::sel_right]  = key_in[p][asteroids_shell_pkg::key_right];
      key_sel[p][asteroids_shell_pkg::sel_left]   = key_in[p][asteroids_shell_pkg::key_left];
      key_sel[p][asteroids_shell_pkg::sel_fire]   = key_in[p][asteroids_shell_pkg::key_face_a];
      key_sel[p][asteroids_shell_pkg::sel_hyper]  = key_in[p][asteroids_shell_pkg::key_face_b];
      key_sel[p][asteroids_shell_pkg::sel_thrust] = key_in[p][asteroids_shell_pkg::key_face_x];
      key_sel[p][asteroids_shell_pkg::sel_spare]  = key_in[p][asteroids_shell_pkg::key_face_y];
      key_sel[p][asteroids_shell_pkg::sel_start]  = key_in[p][asteroids_shell_pkg::key_start];
    end
  end

  //////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////

  // keys arrive as async levels
  always_ff @(posedge clk_25_175 or negedge rst_n) begin
    if (!rst_n) begin
      key_meta <= '0;
      key_sync <= '0;
    end else begin
      key_meta <= key_sel;
      key_sync <= key_meta;
    end
  end

  //////////////////////////////////////////////////
  // button vector
  //////////////////////////////////////////////////

  // shared controls merge both players, starts stay per player
  always_comb begin
    buttons[asteroids_shell_pkg::btn_right] =
      ~(key_sync[0][asteroids_shell_pkg::sel_right] | key_sync[1][asteroids_shell_pkg::sel_right]);
    buttons[asteroids_shell_pkg::btn_left] =
      ~(key_sync[0][asteroids_shell_pkg::sel_left] | key_sync[1][asteroids_shell_pkg::sel_left]);
    buttons[asteroids_shell_pkg::btn_p1_start] = ~key_sync[0][asteroids_shell_pkg::sel_start];
    buttons[asteroids_shell_pkg::btn_p2_start] = ~key_sync[1][asteroids_shell_pkg::sel_start];
    buttons[asteroids_shell_pkg::btn_fire] =
      ~(key_sync[0][asteroids_shell_pkg::sel_fire] | key_sync[1][asteroids_shell_pkg::sel_fire]);
    // spare input, unused by the game logic itself
    buttons[asteroids_shell_pkg::btn_spare] =
      ~(key_sync[0][asteroids_shell_pkg::sel_spare] | key_sync[1][asteroids_shell_pkg::sel_spare]);
    buttons[asteroids_shell_pkg::btn_thrust] =
      ~(key_sync[0][asteroids_shell_pkg::sel_thrust] | key_sync[1][asteroids_shell_pkg::sel_thrust]);
    buttons[asteroids_shell_pkg::btn_hyperspace] =
      ~(key_sync[0][asteroids_shell_pkg::sel_hyper] | key_sync[1][asteroids_shell_pkg::sel_hyper]);
  end

endmodule

//--- logic/scaler_video_out.sv
//////////////////////////////////////////////////
// scaler video output stage
// captures game video, widens 4-bit colour to 24-bit,
// builds data enable and rising-edge sync pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module scaler_video_out (
  input  logic                                        clk_25_175,
  input  logic                                        rst_n,
  input  logic [asteroids_shell_pkg::game_color_w-1:0] game_r,
  input  logic [asteroids_shell_pkg::game_color_w-1:0] game_g,
  input  logic [asteroids_shell_pkg::game_color_w-1:0] game_b,
  input  logic                                        game_hs,
  input  logic                                        game_vs,
  input  logic                                        game_hblank,
  input  logic                                        game_vblank,
  output logic [asteroids_shell_pkg::rgb_w-1:0]        video_rgb,
  output logic                                        video_de,
  output logic                                        video_hs,
  output logic                                        video_vs
);

  // stage 1 capture registers
  logic [asteroids_shell_pkg::game_color_w-1:0] cap_r;
  logic [asteroids_shell_pkg::game_color_w-1:0] cap_g;
  logic [asteroids_shell_pkg::game_color_w-1:0] cap_b;
  logic                                         cap_hs;
  logic                                         cap_vs;
  logic                                         cap_hblank;
  logic                                         cap_vblank;

  // previous captured sync levels, edge reference
  logic hs_prev;
  logic vs_prev;

  // stage 2 combinational terms
  logic                                  de_next;
  logic [asteroids_shell_pkg::rgb_w-1:0] rgb_wide;

  //////////////////////////////////////////////////
  // stage 1 capture
  //////////////////////////////////////////////////

  // all game video signals move together
  always_ff @(posedge clk_25_175 or negedge rst_n) begin
    if (!rst_n) begin
      cap_r      <= '0;
      cap_g      <= '0;
      cap_b      <= '0;
      cap_hs     <= 1'b0;
      cap_vs     <= 1'b0;
      cap_hblank <= 1'b0;
      cap_vblank <= 1'b0;
    end else begin
      cap_r      <= game_r;
      cap_g      <= game_g;
      cap_b      <= game_b;
      cap_hs     <= game_hs;
      cap_vs     <= game_vs;
      cap_hblank <= game_hblank;
      cap_vblank <= game_vblank;
    end
  end

  //////////////////////////////////////////////////
  // stage 2 output
  //////////////////////////////////////////////////

  // active area is outside both blanks
  assign de_next = ~(cap_hblank | cap_vblank);

  // nibble repeated twice per byte, so full scale stays full scale
  assign rgb_wide = {{2{cap_r}}, {2{cap_g}}, {2{cap_b}}};

  always_ff @(posedge clk_25_175 or negedge rst_n) begin
    if (!rst_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_de  <= de_next;
      // black outside the active area
      video_rgb <= de_next ? rgb_wide : '0;
      // one-cycle pulse on each low to high step
      video_hs  <= cap_hs & ~hs_prev;
      video_vs  <= cap_vs & ~vs_prev;
      hs_prev   <= cap_hs;
      vs_prev   <= cap_vs;
    end
  end

endmodule

//--- logic/asteroids_shell_top.sv
//////////////////////////////////////////////////
// asteroids shell top level
// bridge settings, controller buttons and scaler
// video around the external game core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module asteroids_shell_top (
  input  logic                                         clk_25_175,
  input  logic                                         rst_n,

  // host bridge, synchronous to clk_25_175
  input  logic                                         bridge_wr,
  input  logic [asteroids_shell_pkg::bridge_addr_w-1:0] bridge_addr,
  input  logic [asteroids_shell_pkg::bridge_data_w-1:0] bridge_wr_data,

  // settings toward the game core
  output logic [asteroids_shell_pkg::setting_w-1:0]     cs_language,
  output logic [asteroids_shell_pkg::setting_w-1:0]     cs_ship_count,
  output logic                                         self_test_l,

  // controllers in, game buttons out
  input  logic [asteroids_shell_pkg::key_w-1:0]         cont1_key,
  input  logic [asteroids_shell_pkg::key_w-1:0]         cont2_key,
  output logic [asteroids_shell_pkg::button_w-1:0]      buttons,

  // video from the game core
  input  logic [asteroids_shell_pkg::game_color_w-1:0]  game_r,
  input  logic [asteroids_shell_pkg::game_color_w-1:0]  game_g,
  input  logic [asteroids_shell_pkg::game_color_w-1:0]  game_b,
  input  logic                                         game_hs,
  input  logic                                         game_vs,
  input  logic                                         game_hblank,
  input  logic                                         game_vblank,

  // video to the scaler
  output logic [asteroids_shell_pkg::rgb_w-1:0]         video_rgb,
  output logic                                         video_de,
  output logic                                         video_hs,
  output logic                                         video_vs
);

  // setting registers on the bridge
  core_settings_regs u_core_settings_regs (
    .clk_25_175     (clk_25_175),
    .rst_n          (rst_n),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .cs_language    (cs_language),
    .cs_ship_count  (cs_ship_count),
    .self_test_l    (self_test_l)
  );

  // key sync and button mapping
  arcade_controls u_arcade_controls (
    .clk_25_175 (clk_25_175),
    .rst_n      (rst_n),
    .cont1_key  (cont1_key),
    .cont2_key  (cont2_key),
    .buttons    (buttons)
  );

  // game video to scaler format
  scaler_video_out u_scaler_video_out (
    .clk_25_175  (clk_25_175),
    .rst_n       (rst_n),
    .game_r      (game_r),
    .game_g      (game_g),
    .game_b      (game_b),
    .game_hs     (game_hs),
    .game_vs     (game_vs),
    .game_hblank (game_hblank),
    .game_vblank (game_vblank),
    .video_rgb   (video_rgb),
    .video_de    (video_de),
    .video_hs    (video_hs),
    .video_vs    (video_vs)
  );

endmodule

//--- dv/tb_shell_model.svh
//////////////////////////////////////////////////
// testbench reference model
// setting write rule, button mapping and video
// formatting behind a two-deep input history
//////////////////////////////////////////////////

`ifndef TB_SHELL_MODEL_SVH
`define TB_SHELL_MODEL_SVH

// expected setting registers
logic [asteroids_shell_pkg::setting_w-1:0] exp_language;
logic [asteroids_shell_pkg::setting_w-1:0] exp_ship_count;
logic                                      exp_self_test_l;

// input history, oldest first
// video packed as {r, g, b, hs, vs, hblank, vblank}
logic [63:0] key_hist [$];
logic [15:0] vid_hist [$];

// last delayed sync levels, edge reference
logic prev_hs;
logic prev_vs;

task automatic model_reset();
  exp_language    = '0;
  exp_ship_count  = '0;
  exp_self_test_l = 1'b1;
  prev_hs         = 1'b0;
  prev_vs         = 1'b0;
  key_hist.delete();
  vid_hist.delete();
  // reset sync and capture flops act like zero inputs
  repeat (2) begin
    key_hist.push_back(64'h0);
    vid_hist.push_back(16'h0);
  end
endtask

// exact address match, ship count and test mode keep bit 0
task automatic model_write(input logic wr, input logic [31:0] addr,
                           input logic [31:0] data);
  if (wr && addr == asteroids_shell_pkg::cs_language_addr)
    exp_language = data[1:0];
  if (wr && addr == asteroids_shell_pkg::cs_ship_count_addr)
    exp_ship_count = {1'b0, data[0]};
  if (wr && addr == asteroids_shell_pkg::cs_test_mode_addr)
    exp_self_test_l = ~data[0];
endtask

// active-low buttons from two key words
function automatic logic [7:0] map_buttons(input logic [31:0] k1, input logic [31:0] k2);
  logic [7:0]  b;
  logic [31:0] any_key;
  // shared controls merge both players
  any_key = k1 | k2;
  b[asteroids_shell_pkg::btn_right]      = ~any_key[asteroids_shell_pkg::key_right];
  b[asteroids_shell_pkg::btn_left]       = ~any_key[asteroids_shell_pkg::key_left];
  b[asteroids_shell_pkg::btn_p1_start]   = ~k1[asteroids_shell_pkg::key_start];
  b[asteroids_shell_pkg::btn_p2_start]   = ~k2[asteroids_shell_pkg::key_start];
  b[asteroids_shell_pkg::btn_fire]       = ~any_key[asteroids_shell_pkg::key_face_a];
  b[asteroids_shell_pkg::btn_spare]      = ~any_key[asteroids_shell_pkg::key_face_y];
  b[asteroids_shell_pkg::btn_thrust]     = ~any_key[asteroids_shell_pkg::key_face_x];
  b[asteroids_shell_pkg::btn_hyperspace] = ~any_key[asteroids_shell_pkg::key_face_b];
  return b;
endfunction

// scaler view of one delayed video sample
task automatic expect_video(input logic [15:0] v, output logic [23:0] rgb, output logic de,
                            output logic hs, output logic vs);
  de  = ~(v[1] | v[0]);
  rgb = de ? {v[15:12], v[15:12], v[11:8], v[11:8], v[7:4], v[7:4]} : 24'h0;
  // pulse only on a low to high step
  hs      = v[3] & ~prev_hs;
  vs      = v[2] & ~prev_vs;
  prev_hs = v[3];
  prev_vs = v[2];
endtask

`endif

//--- dv/tb_asteroids_shell.sv
//////////////////////////////////////////////////
// asteroids shell testbench
// seeded random bridge, key and video stimulus,
// checked every cycle against the reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_asteroids_shell;

  localparam int clk_period      = 100;
  localparam int drive_delay     = 1;
  localparam int reset_cycles    = 3;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 300;
  // all tests plus reset and slack
  localparam int watchdog_cycles = num_tests * cycles_per_test + 50;

  logic                                         clk_25_175;
  logic                                         rst_n;
  logic                                         bridge_wr;
  logic [asteroids_shell_pkg::bridge_addr_w-1:0] bridge_addr;
  logic [asteroids_shell_pkg::bridge_data_w-1:0] bridge_wr_data;
  logic [asteroids_shell_pkg::setting_w-1:0]     cs_language;
  logic [asteroids_shell_pkg::setting_w-1:0]     cs_ship_count;
  logic                                         self_test_l;
  logic [asteroids_shell_pkg::key_w-1:0]         cont1_key;
  logic [asteroids_shell_pkg::key_w-1:0]         cont2_key;
  logic [asteroids_shell_pkg::button_w-1:0]      buttons;
  logic [asteroids_shell_pkg::game_color_w-1:0]  game_r;
  logic [asteroids_shell_pkg::game_color_w-1:0]  game_g;
  logic [asteroids_shell_pkg::game_color_w-1:0]  game_b;
  logic                                         game_hs;
  logic                                         game_vs;
  logic                                         game_hblank;
  logic                                         game_vblank;
  logic [asteroids_shell_pkg::rgb_w-1:0]         video_rgb;
  logic                                         video_de;
  logic                                         video_hs;
  logic                                         video_vs;

  integer seed;
  int     check_count;
  int     error_count;
  string  test_name [1:num_tests] = '{"reset values", "setting writes", "ignored writes",
                                      "button mapping", "colour and de", "sync pulses"};

  `include "tb_shell_model.svh"

  asteroids_shell_top DUT (.*);

  always #(clk_period / 2) clk_25_175 = ~clk_25_175;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // outputs after this edge reflect inputs from two cycles back
  task automatic check_outputs();
    logic [63:0] keys;
    logic [15:0] vid;
    logic [23:0] exp_rgb;
    logic        exp_de;
    logic        exp_hs;
    logic        exp_vs;
    keys = key_hist.pop_front();
    vid  = vid_hist.pop_front();
    expect_video(vid, exp_rgb, exp_de, exp_hs, exp_vs);
    check_value("buttons", 32'(buttons), 32'(map_buttons(keys[63:32], keys[31:0])));
    check_value("cs_language", 32'(cs_language), 32'(exp_language));
    check_value("cs_ship_count", 32'(cs_ship_count), 32'(exp_ship_count));
    check_value("self_test_l", 32'(self_test_l), 32'(exp_self_test_l));
    check_value("video_rgb", 32'(video_rgb), 32'(exp_rgb));
    check_value("video_de", 32'(video_de), 32'(exp_de));
    check_value("video_hs", 32'(video_hs), 32'(exp_hs));
    check_value("video_vs", 32'(video_vs), 32'(exp_vs));
  endtask

  task automatic record_inputs();
    key_hist.push_back({cont1_key, cont2_key});
    vid_hist.push_back({game_r, game_g, game_b, game_hs, game_vs, game_hblank, game_vblank});
    model_write(bridge_wr, bridge_addr, bridge_wr_data);
  endtask

  task automatic drive_inputs(input int test_id);
    logic [31:0] rnd;
    rnd       = $random(seed);
    bridge_wr = 1'b0;
    case (test_id)
      2, 3: begin
        bridge_wr_data = $random(seed);
        case (rnd[1:0])
          2'd0:    bridge_addr = asteroids_shell_pkg::cs_language_addr;
          2'd1:    bridge_addr = asteroids_shell_pkg::cs_ship_count_addr;
          default: bridge_addr = asteroids_shell_pkg::cs_test_mode_addr;
        endcase
        // test 3 writes only off the map, or reads nothing with wr low
        bridge_wr = (test_id == 2) || rnd[2];
        if (test_id == 3 && rnd[2]) begin
          bridge_addr    = $random(seed);
          // setting addresses have bit 4 clear
          bridge_addr[4] = 1'b1;
        end
      end
      4: begin
        // sparse keys, so not every button reads pressed
        cont1_key = $random(seed) & $random(seed);
        cont2_key = $random(seed) & $random(seed);
      end
      5: begin
        {game_r, game_g, game_b} = rnd[11:0];
        game_hblank = rnd[12] & rnd[13];
        game_vblank = rnd[14] & rnd[15] & rnd[16];
      end
      6: begin
        // slow toggles leave syncs high for stretches
        if (rnd[1:0] == 2'b00) game_hs = ~game_hs;
        if (rnd[3:2] == 2'b00) game_vs = ~game_vs;
      end
      default: ;
    endcase
  endtask

  initial begin
    int errors_before;
    seed           = 23;
    check_count    = 0;
    error_count    = 0;
    clk_25_175     = 1'b0;
    rst_n          = 1'b0;
    bridge_wr      = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
    cont1_key      = '0;
    cont2_key      = '0;
    {game_r, game_g, game_b} = '0;
    {game_hs, game_vs, game_hblank, game_vblank} = '0;
    model_reset();
    repeat (reset_cycles) @(posedge clk_25_175);
    #drive_delay;
    rst_n = 1'b1;

    // reset values before the first active edge
    errors_before = error_count;
    check_value("buttons", 32'(buttons), 32'hff);
    check_value("cs_language", 32'(cs_language), 32'h0);
    check_value("cs_ship_count", 32'(cs_ship_count), 32'h0);
    check_value("self_test_l", 32'(self_test_l), 32'h1);
    check_value("video out", 32'({video_rgb, video_de, video_hs, video_vs}), 32'h0);

    for (int t = 1; t <= num_tests; t++) begin
      if (t > 1) errors_before = error_count;
      repeat (cycles_per_test) begin
        @(posedge clk_25_175);
        #drive_delay;
        check_outputs();
        drive_inputs(t);
        record_inputs();
      end
      $display("test %0d %s: %0d errors", t, test_name[t], error_count - errors_before);
    end

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- src.f
+incdir+dv
logic/asteroids_shell_pkg.sv
logic/core_settings_regs.sv
logic/arcade_controls.sv
logic/scaler_video_out.sv
logic/asteroids_shell_top.sv
dv/tb_asteroids_shell.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the asteroids shell testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f src.f \
  --top-module tb_asteroids_shell \
  -o sim_tb_asteroids_shell

./obj_dir/sim_tb_asteroids_shell | tee sim.log

# the testbench prints its fail message on any failed check or timeout
if grep -q "Checks failed" sim.log; then
  echo "simulation result: FAIL"
  exit 1
fi
echo "simulation result: PASS"
